// File: rtl/bldc_macros.svh
// ====================================================================
// Timing and width constants for the BLDC motor driver
// Values are scaled down so that every ramp and fault state is reachable
// ====================================================================
`ifndef BLDC_MACROS_SVH
`define BLDC_MACROS_SVH

// ==================== Duty cycle and PWM ============================

// Width of every duty value; the PWM counter uses the same width
`define BLDC_DUTY_WIDTH 6

// PWM period in clocks, so a duty of 63 is the largest
`define BLDC_PWM_PERIOD 64

// Clocks with both gates of a phase off around every PWM edge
`define BLDC_DEAD_TIME 2

// ==================== Ramp control ==================================

// First applied duty of the startup ramp
`define BLDC_MIN_DUTY 1

// Clocks between ramp steps of one duty count
`define BLDC_RAMP_STEP_CYCLES 16
`define BLDC_RAMP_CNT_WIDTH 4

// ==================== Hall fault detection ==========================

// Clocks between two fault samples of the synchronized hall code
`define BLDC_HALL_SAMPLE_DIV 8
`define BLDC_HALL_DIV_WIDTH 3

// Equal samples in a row that confirm a fault or a reconnect
`define BLDC_HALL_STEADY_COUNT 4
`define BLDC_HALL_CNT_WIDTH 3

`endif

// File: rtl/motor_pkg.sv
// ====================================================================
// Motor control types: duty value and ramp FSM states
// ====================================================================
`include "bldc_macros.svh"

package motor_pkg;

    // One duty cycle value, compared directly against the PWM counter
    typedef logic [`BLDC_DUTY_WIDTH-1:0] duty_t;

    // States of the duty ramp FSM
    // Stop, error and poll_hall always hold the applied duty at zero
    typedef enum logic [2:0] {
        state_stop,
        state_startup,
        state_run,
        state_spin_up,
        state_spin_down,
        state_poll_hall,
        state_error
    } ramp_state_t;

endpackage

// File: rtl/hall_pkg.sv
// ====================================================================
// Hall sensor types and the six-step commutation table
// ====================================================================

package hall_pkg;

    // The three hall lines, bit 0 is phase A and bit 2 is phase C
    typedef logic [2:0] hall_code_t;

    // A phase marked in neither field is the one held low
    typedef struct packed {
        logic [2:0] pwm_phase;
        logic [2:0] float_phase;
    } phase_drive_t;

    // Maps a hall code to the phase pattern, direction high means forward
    // Reverse rotation swaps the PWM phase and the low phase
    function automatic phase_drive_t commutate(hall_code_t code, logic direction);
        phase_drive_t drive;
        logic [2:0]   low_phase;
        case (code)
            3'b101:  drive = '{pwm_phase: 3'b001, float_phase: 3'b100};
            3'b100:  drive = '{pwm_phase: 3'b001, float_phase: 3'b010};
            3'b110:  drive = '{pwm_phase: 3'b010, float_phase: 3'b001};
            3'b010:  drive = '{pwm_phase: 3'b010, float_phase: 3'b100};
            3'b011:  drive = '{pwm_phase: 3'b100, float_phase: 3'b010};
            3'b001:  drive = '{pwm_phase: 3'b100, float_phase: 3'b001};
            // Codes 000 and 111 are faults and leave every phase floating
            default: drive = '{pwm_phase: 3'b000, float_phase: 3'b111};
        endcase
        low_phase = ~(drive.pwm_phase | drive.float_phase);
        if (!direction) begin
            // The old PWM phase becomes the low phase by elimination
            drive.pwm_phase = low_phase;
        end
        return drive;
    endfunction

endpackage

// File: rtl/hall_status_if.sv
// ====================================================================
// Sensor status bus from the hall monitor to the ramp controller
// ====================================================================
`timescale 1ns/1ps

interface hall_status_if import hall_pkg::*; ();

    // Registered hall code, also used for commutation
    hall_code_t hall_sync;
    // Steady 111 seen, sensor cable unplugged
    logic       disconnected;
    // Steady 000 seen, sensor or wiring broken
    logic       hardware_fault;
    // Single cycle pulse when either fault is first confirmed
    logic       fault_strike;
    // Ramp controller is waiting for the sensor to come back
    logic       polling;

    modport monitor (output hall_sync, disconnected, hardware_fault, fault_strike,
                     input polling);

    modport control (input hall_sync, disconnected, hardware_fault, fault_strike,
                     output polling);

endinterface

// File: rtl/hall_monitor.sv
// ====================================================================
// Hall input synchronizer and steady-code fault detector
// ====================================================================
`timescale 1ns/1ps
`include "bldc_macros.svh"

module hall_monitor import hall_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           en,
    input  hall_code_t     hall,
    hall_status_if.monitor status
);

    localparam logic [`BLDC_HALL_DIV_WIDTH-1:0] div_last =
        `BLDC_HALL_DIV_WIDTH'(`BLDC_HALL_SAMPLE_DIV - 1);
    localparam logic [`BLDC_HALL_CNT_WIDTH-1:0] steady_count =
        `BLDC_HALL_CNT_WIDTH'(`BLDC_HALL_STEADY_COUNT);

    logic [`BLDC_HALL_DIV_WIDTH-1:0] div_cnt;
    logic [`BLDC_HALL_CNT_WIDTH-1:0] zero_cnt;
    logic [`BLDC_HALL_CNT_WIDTH-1:0] ones_cnt;
    logic [`BLDC_HALL_CNT_WIDTH-1:0] valid_cnt;
    logic                            sample_tick;
    logic                            code_valid;
    logic                            counting;

    assign sample_tick = (div_cnt == div_last);
    assign code_valid  = !(status.hall_sync inside {3'b000, 3'b111});
    // New faults are searched for only while none is latched
    assign counting    = !status.hardware_fault && !status.disconnected;

    // The sensor lines come from off chip and are registered once
    always_ff @(posedge clk) begin
        status.hall_sync <= hall;
    end

    always_ff @(posedge clk) begin
        if (reset || sample_tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ==================== Steady-code counters and fault latches ======
    always_ff @(posedge clk) begin
        if (reset || !en) begin
            zero_cnt              <= '0;
            ones_cnt              <= '0;
            valid_cnt             <= '0;
            status.hardware_fault <= 1'b0;
            status.disconnected   <= 1'b0;
            status.fault_strike   <= 1'b0;
        end else begin
            status.fault_strike <= 1'b0;
            if (zero_cnt == steady_count) begin
                status.hardware_fault <= 1'b1;
                status.fault_strike   <= 1'b1;
                zero_cnt              <= '0;
            end else if (ones_cnt == steady_count) begin
                status.disconnected <= 1'b1;
                status.fault_strike <= 1'b1;
                ones_cnt            <= '0;
            end else if (valid_cnt == steady_count) begin
                status.disconnected <= 1'b0;
                valid_cnt           <= '0;
            end else if (status.hardware_fault && status.hall_sync == 3'b111) begin
                // Unplugging a broken sensor turns the fault into a disconnect
                status.hardware_fault <= 1'b0;
                status.disconnected   <= 1'b1;
            end else if (sample_tick) begin
                if (counting && status.hall_sync == 3'b000) begin
                    zero_cnt <= zero_cnt + 1'b1;
                    ones_cnt <= '0;
                end else if (counting && status.hall_sync == 3'b111) begin
                    ones_cnt <= ones_cnt + 1'b1;
                    zero_cnt <= '0;
                end else begin
                    zero_cnt <= '0;
                    ones_cnt <= '0;
                end
                // Reconnect needs valid codes in a row while the ramp polls
                if (status.polling && code_valid) begin
                    valid_cnt <= valid_cnt + 1'b1;
                end else begin
                    valid_cnt <= '0;
                end
            end
        end
    end

    // The ramp FSM takes exactly one transition per confirmed fault
    assert property (@(posedge clk) disable iff (reset)
        status.fault_strike |=> !status.fault_strike);

    assert property (@(posedge clk) disable iff (reset)
        !(status.hardware_fault && status.disconnected));

endmodule

// File: rtl/duty_ramp.sv
// ====================================================================
// Motor FSM that ramps the applied duty toward the commanded duty
// ====================================================================
`timescale 1ns/1ps
`include "bldc_macros.svh"

module duty_ramp import motor_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           en,
    input  duty_t          duty_cycle,
    hall_status_if.control status,
    output duty_t          duty_applied,
    output logic           fault
);

    localparam duty_t min_duty = duty_t'(`BLDC_MIN_DUTY);
    localparam logic [`BLDC_RAMP_CNT_WIDTH-1:0] step_last =
        `BLDC_RAMP_CNT_WIDTH'(`BLDC_RAMP_STEP_CYCLES - 1);

    ramp_state_t                     state;
    logic [`BLDC_RAMP_CNT_WIDTH-1:0] step_cnt;
    logic                            step_tick;

    // One ramp step of one duty count per timer wrap
    assign step_tick = (step_cnt == step_last);

    // The monitor only counts reconnect samples while this is high
    assign status.polling = (state == state_poll_hall);

    always_ff @(posedge clk) begin
        if (reset || !en) begin
            state        <= state_stop;
            duty_applied <= '0;
            step_cnt     <= '0;
            fault        <= 1'b0;
        end else if (status.fault_strike) begin
            // Any confirmed fault removes drive at once
            duty_applied <= '0;
            step_cnt     <= '0;
            state        <= status.disconnected ? state_poll_hall : state_error;
        end else begin
            step_cnt <= step_tick ? '0 : step_cnt + 1'b1;
            case (state)
                state_stop: begin
                    duty_applied <= '0;
                    if (duty_cycle > min_duty) begin
                        duty_applied <= min_duty;
                        step_cnt     <= '0;
                        state        <= state_startup;
                    end
                end
                state_startup: begin
                    if (duty_cycle <= min_duty) begin
                        duty_applied <= '0;
                        state        <= state_stop;
                    end else if (duty_applied >= duty_cycle) begin
                        // A lowered command is handled by spin_down from run
                        state <= state_run;
                    end else if (step_tick) begin
                        duty_applied <= duty_applied + 1'b1;
                    end
                end
                state_run: begin
                    step_cnt <= '0;
                    if (duty_cycle > duty_applied) begin
                        state <= state_spin_up;
                    end else if (duty_cycle < duty_applied) begin
                        state <= state_spin_down;
                    end
                end
                state_spin_up: begin
                    if (duty_applied == duty_cycle) begin
                        state <= state_run;
                    end else if (duty_applied > duty_cycle) begin
                        state <= state_spin_down;
                    end else if (step_tick) begin
                        duty_applied <= duty_applied + 1'b1;
                    end
                end
                state_spin_down: begin
                    if (duty_applied == '0) begin
                        state <= state_stop;
                    end else if (duty_applied == duty_cycle) begin
                        state <= state_run;
                    end else if (duty_applied < duty_cycle) begin
                        state <= state_spin_up;
                    end else if (step_tick) begin
                        duty_applied <= duty_applied - 1'b1;
                    end
                end
                state_poll_hall: begin
                    // Restart through spin_down, which falls straight into stop
                    if (!status.disconnected) begin
                        state <= state_spin_down;
                    end
                end
                state_error: begin
                    fault <= 1'b1;
                    if (status.disconnected) begin
                        fault <= 1'b0;
                        state <= state_poll_hall;
                    end
                end
                default: begin
                    duty_applied <= '0;
                    state        <= state_stop;
                end
            endcase
        end
    end

    // No gate may switch while the FSM is idle or waiting on a fault
    assert property (@(posedge clk) disable iff (reset)
        (state inside {state_stop, state_error, state_poll_hall}) |-> duty_applied == '0);

endmodule

// File: rtl/pwm_bridge.sv
// ====================================================================
// Shared PWM counter, commutation lookup and dead-timed gate outputs
// for the three half bridges
// ====================================================================
`timescale 1ns/1ps
`include "bldc_macros.svh"

module pwm_bridge import motor_pkg::*, hall_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       en,
    input  hall_code_t hall_sync,
    input  logic       direction,
    input  duty_t      duty_applied,
    output logic [2:0] phase_h,
    output logic [2:0] phase_l
);

    // One extra bit so that duty plus dead time cannot wrap
    localparam int unsigned ext_width = `BLDC_DUTY_WIDTH + 1;
    localparam duty_t period_last = duty_t'(`BLDC_PWM_PERIOD - 1);
    localparam logic [ext_width-1:0] dead_time = ext_width'(`BLDC_DEAD_TIME);

    duty_t                pwm_cnt;
    phase_drive_t         drive;
    logic [2:0]           low_phase;
    logic [ext_width-1:0] cnt_ext;
    logic [ext_width-1:0] duty_ext;
    logic                 high_on;
    logic                 low_on;
    logic [2:0]           phase_h_next;
    logic [2:0]           phase_l_next;

    // Free-running counter shared by all three phases
    always_ff @(posedge clk) begin
        if (reset || pwm_cnt == period_last) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    assign drive     = commutate(hall_sync, direction);
    assign low_phase = ~(drive.pwm_phase | drive.float_phase);

    // ==================== PWM window with dead time ===================
    assign cnt_ext  = {1'b0, pwm_cnt};
    assign duty_ext = {1'b0, duty_applied};

    // High side from dead_time to duty, low side from duty + dead_time to the end
    // Both sides are off for dead_time clocks around each edge
    assign high_on = (cnt_ext >= dead_time) && (cnt_ext < duty_ext);
    assign low_on  = (cnt_ext >= duty_ext + dead_time);

    // The low phase keeps its low side on, a floating phase has both off
    assign phase_h_next = drive.pwm_phase & {3{high_on}};
    assign phase_l_next = (drive.pwm_phase & {3{low_on}}) | low_phase;

    always_ff @(posedge clk) begin
        if (reset || !en) begin
            phase_h <= 3'b000;
            phase_l <= 3'b000;
        end else begin
            phase_h <= phase_h_next;
            phase_l <= phase_l_next;
        end
    end

    // Shoot-through guard across commutation changes and PWM edges
    assert property (@(posedge clk) disable iff (reset)
        (phase_h & phase_l) == 3'b000);

endmodule

// File: rtl/bldc_driver.sv
// ====================================================================
// BLDC driver top level with hall monitor, duty ramp and PWM bridge
// ====================================================================
`timescale 1ns/1ps

module bldc_driver import motor_pkg::*, hall_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       en,
    input  hall_code_t hall,
    input  duty_t      duty_cycle,
    input  logic       direction,
    output logic [2:0] phase_h,
    output logic [2:0] phase_l,
    output logic       connected,
    output logic       fault
);

    duty_t duty_applied;

    hall_status_if status_bus ();

    // Sensor status producer
    hall_monitor u_hall_monitor (
        .clk    (clk),
        .reset  (reset),
        .en     (en),
        .hall   (hall),
        .status (status_bus.monitor)
    );

    duty_ramp u_duty_ramp (
        .clk          (clk),
        .reset        (reset),
        .en           (en),
        .duty_cycle   (duty_cycle),
        .status       (status_bus.control),
        .duty_applied (duty_applied),
        .fault        (fault)
    );

    // Gate driver, commutated from the same registered hall code
    pwm_bridge u_pwm_bridge (
        .clk          (clk),
        .reset        (reset),
        .en           (en),
        .hall_sync    (status_bus.hall_sync),
        .direction    (direction),
        .duty_applied (duty_applied),
        .phase_h      (phase_h),
        .phase_l      (phase_l)
    );

    assign connected = ~status_bus.disconnected;

endmodule

// File: tests/tb_bldc_driver.sv
// ======================================================================
// Testbench for the BLDC driver with clock, reset, gate time measurement
// and directed tests for ramp, commutation, disconnect and hardware fault
// ======================================================================
`timescale 1ns/1ps
`include "bldc_macros.svh"

module tb_bldc_driver import motor_pkg::*, hall_pkg::*; ();

    localparam int period   = `BLDC_PWM_PERIOD;
    localparam int dead     = `BLDC_DEAD_TIME;
    localparam int step     = `BLDC_RAMP_STEP_CYCLES;
    localparam int run_duty = 40;
    // Ramp bounds in clocks, with three PWM periods of slack for measuring
    localparam int ramp_limit  = (run_duty - 1) * step + 3 * period;
    localparam int stop_limit  = run_duty * step + 3 * period;
    // Worst confirmation latency of a steady hall code plus a small margin
    localparam int fault_limit = `BLDC_HALL_STEADY_COUNT * `BLDC_HALL_SAMPLE_DIV + 2 + 4;

    logic       clk;
    logic       reset;
    logic       en;
    hall_code_t hall;
    duty_t      duty_cycle;
    logic       direction;
    logic [2:0] phase_h;
    logic [2:0] phase_l;
    logic       connected;
    logic       fault;

    // Clocks high per phase over the last measured PWM period
    int          h_count [3];
    int          l_count [3];
    hall_code_t  valid_codes [6] = '{3'b101, 3'b100, 3'b110, 3'b010, 3'b011, 3'b001};
    hall_code_t  run_code;
    int unsigned seed_result;

    bldc_driver u_dut (
        .clk        (clk),
        .reset      (reset),
        .en         (en),
        .hall       (hall),
        .duty_cycle (duty_cycle),
        .direction  (direction),
        .phase_h    (phase_h),
        .phase_l    (phase_l),
        .connected  (connected),
        .fault      (fault)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==================== Error reporting ==============================
    task automatic abort_run;
        $display("Test failures found");
        $fatal(1, "stopped at the first failed check");
    endtask

    task automatic report_value(input string name, input int expected, input int actual);
        $display("ERR at %0t: %s expected %0d got %0d", $time, name, expected, actual);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        $display("At %0t: %s", $time, what);
        abort_run();
    endtask

    task automatic compare_value(input string name, input int expected, input int actual);
        assert (actual == expected) else report_value(name, expected, actual);
    endtask

    // ==================== Stimulus and measurement =====================
    // Inputs change 1 ns after the rising edge, outputs are read at the falling edge
    task automatic drive_hall(input hall_code_t code, input logic dir);
        @(posedge clk);
        #1;
        hall      = code;
        direction = dir;
    endtask

    task automatic drive_duty(input int duty);
        @(posedge clk);
        #1;
        duty_cycle = duty_t'(duty);
    endtask

    task automatic measure_period;
        for (int p = 0; p < 3; p++) begin
            h_count[p] = 0;
            l_count[p] = 0;
        end
        repeat (period) begin
            @(negedge clk);
            assert ((phase_h & phase_l) == 3'b000) else
                report_problem("phase_h and phase_l of one phase are high together");
            for (int p = 0; p < 3; p++) begin
                if (phase_h[p]) h_count[p]++;
                if (phase_l[p]) l_count[p]++;
            end
        end
    endtask

    // Forward table with phase index 0 for A and 2 for C
    function automatic int table_pwm(hall_code_t code);
        case (code)
            3'b101, 3'b100: return 0;
            3'b110, 3'b010: return 1;
            default:        return 2;
        endcase
    endfunction

    function automatic int table_low(hall_code_t code);
        case (code)
            3'b010, 3'b011: return 0;
            3'b101, 3'b001: return 1;
            default:        return 2;
        endcase
    endfunction

    // Reverse rotation swaps the pwm phase and the low phase
    function automatic int active_pwm(hall_code_t code, logic dir);
        return dir ? table_pwm(code) : table_low(code);
    endfunction

    task automatic verify_pattern(input hall_code_t code, input logic dir, input int duty);
        int pwm_idx;
        int low_idx;
        int float_idx;
        int pwm_h;
        int pwm_l;
        pwm_idx   = active_pwm(code, dir);
        low_idx   = dir ? table_low(code) : table_pwm(code);
        float_idx = 3 - pwm_idx - low_idx;
        // High side from dead time to duty, low side from duty plus dead time on
        pwm_h = (duty > dead) ? duty - dead : 0;
        pwm_l = (period - duty - dead > 0) ? period - duty - dead : 0;
        compare_value($sformatf("phase_h[%0d] pwm", pwm_idx), pwm_h, h_count[pwm_idx]);
        compare_value($sformatf("phase_l[%0d] pwm", pwm_idx), pwm_l, l_count[pwm_idx]);
        compare_value($sformatf("phase_h[%0d] low", low_idx), 0, h_count[low_idx]);
        compare_value($sformatf("phase_l[%0d] low", low_idx), period, l_count[low_idx]);
        compare_value($sformatf("phase_h[%0d] float", float_idx), 0, h_count[float_idx]);
        compare_value($sformatf("phase_l[%0d] float", float_idx), 0, l_count[float_idx]);
    endtask

    task automatic expect_all_off;
        measure_period();
        for (int p = 0; p < 3; p++) begin
            compare_value($sformatf("phase_h[%0d]", p), 0, h_count[p]);
            compare_value($sformatf("phase_l[%0d]", p), 0, l_count[p]);
        end
    endtask

    // ==================== Bounded waits ================================
    // The measured high time may only grow while the ramp climbs
    task automatic wait_high_time(input int idx, input int target, input int limit);
        int elapsed;
        int prev;
        elapsed = period;
        prev    = 0;
        measure_period();
        while (h_count[idx] != target) begin
            assert (h_count[idx] >= prev) else
                report_value($sformatf("phase_h[%0d] rising high time", idx),
                             prev, h_count[idx]);
            assert (elapsed < limit) else
                report_problem($sformatf("high time did not reach %0d in %0d clocks",
                                         target, limit));
            prev = h_count[idx];
            measure_period();
            elapsed += period;
        end
    endtask

    task automatic wait_high_sides_off(input int limit);
        int elapsed;
        elapsed = period;
        measure_period();
        while (h_count[0] + h_count[1] + h_count[2] != 0) begin
            assert (elapsed < limit) else
                report_problem($sformatf("phase_h still switching after %0d clocks", limit));
            measure_period();
            elapsed += period;
        end
    endtask

    task automatic wait_connected(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (connected !== level) begin
            assert (cycles < fault_limit) else
                report_problem($sformatf("connected not %0b within %0d clocks",
                                         level, fault_limit));
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic wait_fault_high;
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (fault !== 1'b1) begin
            assert (cycles < fault_limit) else
                report_problem($sformatf("fault did not rise within %0d clocks", fault_limit));
            @(negedge clk);
            cycles++;
        end
    endtask

    // ==================== Directed tests ===============================
    task automatic check_reset_state;
        // Two clocks for the hall register and the gate registers
        repeat (2) @(posedge clk);
        measure_period();
        verify_pattern(run_code, direction, 0);
        compare_value("fault", 0, int'(fault));
        compare_value("connected", 1, int'(connected));
    endtask

    task automatic run_startup_ramp;
        drive_duty(run_duty);
        wait_high_time(active_pwm(run_code, direction), run_duty - dead, ramp_limit);
        measure_period();
        verify_pattern(run_code, direction, run_duty);
    endtask

    task automatic sweep_commutation;
        int order [12];
        int pick;
        int swap;
        hall_code_t code;
        logic dir;
        for (int i = 0; i < 12; i++) order[i] = i;
        // Shuffle of every code and direction pair
        for (int i = 11; i > 0; i--) begin
            pick        = int'($urandom % (i + 1));
            swap        = order[i];
            order[i]    = order[pick];
            order[pick] = swap;
        end
        for (int k = 0; k < 12; k++) begin
            code = valid_codes[order[k] / 2];
            dir  = (order[k] % 2) == 1;
            drive_hall(code, dir);
            // The settle period spans the commutation change and is watched for overlap too
            measure_period();
            measure_period();
            verify_pattern(code, dir, run_duty);
        end
        drive_hall(run_code, 1'b1);
    endtask

    task automatic run_spin_down;
        drive_duty(0);
        wait_high_sides_off(stop_limit);
    endtask

    task automatic cycle_disconnect;
        drive_duty(run_duty);
        wait_high_time(active_pwm(run_code, direction), run_duty - dead, ramp_limit);
        drive_hall(3'b111, direction);
        wait_connected(1'b0);
        compare_value("phase_h", 0, int'(phase_h));
        compare_value("phase_l", 0, int'(phase_l));
        expect_all_off();
        compare_value("fault", 0, int'(fault));
        // Reconnect on a fresh valid code, the ramp then starts again from stop
        run_code = valid_codes[int'($urandom % 6)];
        drive_hall(run_code, direction);
        wait_connected(1'b1);
        wait_high_time(active_pwm(run_code, direction), run_duty - dead, ramp_limit + period);
    endtask

    task automatic raise_hardware_fault;
        drive_hall(3'b000, direction);
        wait_fault_high();
        compare_value("connected", 1, int'(connected));
        expect_all_off();
        compare_value("fault", 1, int'(fault));
        // One clock of en low clears the latched fault
        @(posedge clk);
        #1;
        en   = 1'b0;
        hall = run_code;
        @(posedge clk);
        #1;
        en = 1'b1;
        @(negedge clk);
        compare_value("phase_h", 0, int'(phase_h));
        compare_value("phase_l", 0, int'(phase_l));
        repeat (fault_limit) begin
            compare_value("fault", 0, int'(fault));
            @(negedge clk);
        end
    endtask

    initial begin
        reset      = 1'b1;
        en         = 1'b1;
        hall       = 3'b101;
        duty_cycle = '0;
        direction  = 1'b1;
        seed_result = $urandom(32'hfa40_2f1f);
        run_code    = valid_codes[int'(seed_result % 6)];
        hall        = run_code;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        check_reset_state();
        run_startup_ramp();
        sweep_commutation();
        run_spin_down();
        cycle_disconnect();
        raise_hardware_fault();
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: tb.f
+incdir+rtl
rtl/motor_pkg.sv
rtl/hall_pkg.sv
rtl/hall_status_if.sv
rtl/hall_monitor.sv
rtl/duty_ramp.sv
rtl/pwm_bridge.sv
rtl/bldc_driver.sv
tests/tb_bldc_driver.sv

// File: Makefile
# Verilator flow for the BLDC driver testbench

VERILATOR  := verilator
TOP        := tb_bldc_driver
FILE_LIST  := tb.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

# The run passes only when the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
